/* cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath word width in bits
`define WORD_W 32

// General purpose registers
`define NUM_REGS 16

// Word memory size and access latency in cycles
`define MEM_DEPTH 512
`define MEM_LAT 3

// Iterations of the shift-add multiply and restoring divide
`define DIV_STEPS 32

`endif

/* cpuPkg.sv */
`include "cpu_params.svh"

package cpuPkg;

	typedef logic [`WORD_W-1:0] wordT;
	// HI lives in the upper word
	typedef logic [2*`WORD_W-1:0] dwordT;
	typedef logic [$clog2(`NUM_REGS)-1:0] regIdxT;

	typedef enum logic [4:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_SHR,
		OP_SHRA,
		OP_SHL,
		OP_ROR,
		OP_ROL,
		OP_NEG,
		OP_NOT,
		OP_MUL,
		OP_DIV
	} aluOpT;

	// Bus drivers, at most one set per cycle
	typedef struct packed {
		logic ext;
		logic rf;
		logic pc;
		logic ir;
		logic ry;
		logic rzLo;
		logic rzHi;
		logic hi;
		logic lo;
		logic mdr;
		logic imm;
		logic inport;
	} busSrcT;

	// Register load enables
	typedef struct packed {
		logic pc;
		logic ir;
		logic ry;
		logic rz;
		logic hi;
		logic lo;
		logic mar;
		logic mdr;
		logic outport;
	} regLoadT;

	// Branch condition in IR bits 20:19
	typedef enum logic [1:0] {
		CC_ZERO,
		CC_NONZERO,
		CC_POS,
		CC_NEG
	} condT;

endpackage

/* DataReg.sv */
`timescale 1ns/100ps

module DataReg #(
	parameter type T = logic,
	parameter T RESET_VAL = '0
) (
	input logic clock,
	input logic arstN,
	input logic load,
	input T d,
	output T q
);

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			q <= RESET_VAL;
		end else if (load) begin
			q <= d;
		end
	end

endmodule

/* RegFile.sv */
`timescale 1ns/100ps
`include "cpu_params.svh"

module RegFile (
	input logic clock,
	input logic arstN,
	input logic wrEn,
	input cpuPkg::regIdxT idx,
	input logic baOut,
	input cpuPkg::wordT wrData,
	output cpuPkg::wordT rdData
);
	import cpuPkg::*;

	wordT regs [`NUM_REGS];

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[idx] <= wrData;
		end
	end

	// r0 reads as zero for base-address forms
	assign rdData = (baOut && idx == '0) ? '0 : regs[idx];

endmodule

/* RegSelect.sv */
`timescale 1ns/100ps

module RegSelect (
	input cpuPkg::wordT ir,
	input logic gra,
	input logic grb,
	input logic grc,
	input logic rIn,
	input logic rOut,
	input logic baOut,
	output cpuPkg::regIdxT idx,
	output logic wrEn,
	output logic rdEn,
	output cpuPkg::wordT imm
);
	import cpuPkg::*;

	// Field positions of ra, rb and rc
	always_comb begin
		if (gra) begin
			idx = ir[26:23];
		end else if (grb) begin
			idx = ir[22:19];
		end else if (grc) begin
			idx = ir[18:15];
		end else begin
			idx = '0;
		end
	end

	assign wrEn = rIn;
	// Base-address read also drives the bus
	assign rdEn = rOut | baOut;

	// Constant field C sign-extended to a word
	assign imm = {{($bits(wordT) - 19){ir[18]}}, ir[18:0]};

	// Strobes come from the controller, only one field at a time
	selOneField: assert final ($onehot0({gra, grb, grc}))
		else $error("more than one register field strobe set");

endmodule

/* BranchCond.sv */
`timescale 1ns/100ps

module BranchCond (
	input logic clock,
	input logic arstN,
	input logic condIn,
	input cpuPkg::wordT ir,
	input cpuPkg::wordT regVal,
	output logic branch
);
	import cpuPkg::*;

	localparam int SignBit = $bits(wordT) - 1;

	condT cond;
	logic met;

	assign cond = condT'(ir[20:19]);

	always_comb begin
		case (cond)
			CC_ZERO: met = (regVal == '0);
			CC_NONZERO: met = (regVal != '0);
			CC_POS: met = !regVal[SignBit] && (regVal != '0);
			default: met = regVal[SignBit];
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			branch <= 1'b0;
		end else if (condIn) begin
			branch <= met;
		end
	end

endmodule

/* Alu.sv */
`timescale 1ns/100ps
`include "cpu_params.svh"

module Alu (
	input logic clock,
	input logic arstN,
	input logic start,
	input cpuPkg::aluOpT op,
	input cpuPkg::wordT a,
	input cpuPkg::wordT b,
	output cpuPkg::dwordT z,
	output logic finished
);
	import cpuPkg::*;

	localparam int W = `WORD_W;
	localparam int ShW = $clog2(W);
	localparam int CntW = $clog2(`DIV_STEPS);

	aluOpT opReg;
	wordT aReg;
	wordT bReg;
	// Magnitude of multiplicand or divisor
	wordT opnd;
	// Product for MUL, remainder over quotient for DIV
	logic [2*W:0] acc;
	logic [CntW-1:0] stepCnt;
	logic busy;
	logic longOp;
	logic [ShW-1:0] shAmt;
	dwordT rotBuf;
	wordT shortRes;
	logic [W:0] mulSum;
	logic [W+1:0] divTrial;
	logic negRes;

	function automatic wordT magOf(input wordT v);
		return v[W-1] ? -v : v;
	endfunction

	assign longOp = (op == OP_MUL) || (op == OP_DIV);
	assign shAmt = bReg[ShW-1:0];
	assign negRes = aReg[W-1] ^ bReg[W-1];

	// One shift-add step on the upper half
	assign mulSum = acc[2*W:W] + (acc[0] ? {1'b0, opnd} : '0);
	// Trial subtract of the shifted remainder
	assign divTrial = {1'b0, acc[2*W-1:W-1]} - {2'b00, opnd};

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			opReg <= OP_ADD;
			busy <= 1'b0;
			stepCnt <= '0;
			finished <= 1'b0;
		end else begin
			finished <= 1'b0;
			if (start) begin
				opReg <= op;
				stepCnt <= '0;
				busy <= longOp;
				finished <= !longOp;
			end else if (busy) begin
				stepCnt <= stepCnt + 1'b1;
				if (stepCnt == CntW'(`DIV_STEPS - 1)) begin
					busy <= 1'b0;
					finished <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			aReg <= a;
			bReg <= b;
			opnd <= (op == OP_MUL) ? magOf(a) : magOf(b);
			// Multiplier or dividend starts in the low word
			acc <= {{(W + 1){1'b0}}, (op == OP_MUL) ? magOf(b) : magOf(a)};
		end else if (busy) begin
			if (opReg == OP_MUL) begin
				acc <= {mulSum, acc[W-1:0]} >> 1;
			end else if (divTrial[W+1]) begin
				acc <= {1'b0, acc[2*W-2:0], 1'b0};
			end else begin
				acc <= {1'b0, divTrial[W-1:0], acc[W-2:0], 1'b1};
			end
		end
	end

	always_comb begin
		rotBuf = {aReg, aReg};
		case (opReg)
			OP_ADD: shortRes = aReg + bReg;
			OP_SUB: shortRes = aReg - bReg;
			OP_AND: shortRes = aReg & bReg;
			OP_OR: shortRes = aReg | bReg;
			OP_SHR: shortRes = aReg >> shAmt;
			OP_SHRA: shortRes = $signed(aReg) >>> shAmt;
			OP_SHL: shortRes = aReg << shAmt;
			OP_ROR: begin
				rotBuf = {aReg, aReg} >> shAmt;
				shortRes = rotBuf[W-1:0];
			end
			OP_ROL: begin
				rotBuf = {aReg, aReg} << shAmt;
				shortRes = rotBuf[2*W-1:W];
			end
			OP_NEG: shortRes = -bReg;
			OP_NOT: shortRes = ~bReg;
			default: shortRes = '0;
		endcase
	end

	// Sign fix-up after the unsigned iterations
	always_comb begin
		case (opReg)
			OP_MUL: z = negRes ? -acc[2*W-1:0] : acc[2*W-1:0];
			OP_DIV: z = {aReg[W-1] ? -acc[2*W-1:W] : acc[2*W-1:W],
					negRes ? -acc[W-1:0] : acc[W-1:0]};
			default: z = {{W{1'b0}}, shortRes};
		endcase
	end

	noStartWhileBusy: assert property (@(posedge clock) disable iff (!arstN)
		start |-> !busy)
		else $error("ALU started during a multi-cycle operation");

endmodule

/* MemSys.sv */
`timescale 1ns/100ps
`include "cpu_params.svh"

module MemSys (
	input logic clock,
	input logic arstN,
	input logic read,
	input logic write,
	input logic marIn,
	input logic mdrIn,
	input cpuPkg::wordT bus,
	output cpuPkg::wordT mdrOut,
	output logic memFinished
);
	import cpuPkg::*;

	localparam int AddrW = $clog2(`MEM_DEPTH);
	localparam int CntW = $clog2(`MEM_LAT + 1);

	wordT mem [`MEM_DEPTH];
	wordT mar;
	logic [AddrW-1:0] addr;
	logic [CntW-1:0] latCnt;
	logic busy;
	logic isWrite;
	logic done;

	assign addr = mar[AddrW-1:0];
	// Last cycle of the access
	assign done = busy && (latCnt == CntW'(1));

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			mar <= '0;
			mdrOut <= '0;
			latCnt <= '0;
			busy <= 1'b0;
			isWrite <= 1'b0;
			memFinished <= 1'b0;
		end else begin
			memFinished <= done;
			if (marIn) begin
				mar <= bus;
			end
			// Read data wins over a bus load
			if (done && !isWrite) begin
				mdrOut <= mem[addr];
			end else if (mdrIn) begin
				mdrOut <= bus;
			end
			if (done) begin
				busy <= 1'b0;
			end else if (busy) begin
				latCnt <= latCnt - 1'b1;
			end else if (read || write) begin
				busy <= 1'b1;
				isWrite <= write;
				latCnt <= CntW'(`MEM_LAT - 1);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (done && isWrite) begin
			mem[addr] <= mdrOut;
		end
	end

	noReadWrite: assert property (@(posedge clock) disable iff (!arstN)
		!(read && write))
		else $error("memory read and write strobes together");

endmodule

/* BusMux.sv */
`timescale 1ns/100ps

module BusMux (
	input cpuPkg::busSrcT sel,
	input cpuPkg::wordT ext,
	input cpuPkg::wordT rf,
	input cpuPkg::wordT pc,
	input cpuPkg::wordT ir,
	input cpuPkg::wordT ry,
	input cpuPkg::wordT rzLo,
	input cpuPkg::wordT rzHi,
	input cpuPkg::wordT hi,
	input cpuPkg::wordT lo,
	input cpuPkg::wordT mdr,
	input cpuPkg::wordT imm,
	input cpuPkg::wordT inport,
	output cpuPkg::wordT bus
);

	// AND-OR select, an idle bus reads zero
	always_comb begin
		bus = '0;
		if (sel.ext) bus |= ext;
		if (sel.rf) bus |= rf;
		if (sel.pc) bus |= pc;
		if (sel.ir) bus |= ir;
		if (sel.ry) bus |= ry;
		if (sel.rzLo) bus |= rzLo;
		if (sel.rzHi) bus |= rzHi;
		if (sel.hi) bus |= hi;
		if (sel.lo) bus |= lo;
		if (sel.mdr) bus |= mdr;
		if (sel.imm) bus |= imm;
		if (sel.inport) bus |= inport;
	end

	busOneDriver: assert final ($onehot0(sel))
		else $error("more than one bus driver selected");

endmodule

/* DataPath.sv */
`timescale 1ns/100ps

module DataPath (
	input logic clock,
	input logic arstN,
	input cpuPkg::busSrcT busSrc,
	input cpuPkg::regLoadT regLoad,
	input logic gra,
	input logic grb,
	input logic grc,
	input logic rIn,
	input logic rOut,
	input logic baOut,
	input logic incPc,
	input logic condIn,
	input logic start,
	input logic read,
	input logic write,
	input logic deviceStrobe,
	input cpuPkg::aluOpT opSelect,
	input cpuPkg::wordT extIn,
	input cpuPkg::wordT deviceIn,
	output logic finished,
	output logic memFinished,
	output logic branch,
	output cpuPkg::wordT deviceOut
);
	import cpuPkg::*;

	wordT bus;
	wordT rfData;
	wordT pcQ;
	wordT pcNext;
	wordT irQ;
	wordT ryQ;
	wordT hiQ;
	wordT loQ;
	wordT mdrQ;
	wordT imm;
	wordT inportQ;
	dwordT aluZ;
	dwordT rzQ;
	regIdxT rfIdx;
	logic rfWrEn;
	logic rfRdEn;
	busSrcT busSel;

	// Register file drives the bus through its own read enable
	always_comb begin
		busSel = busSrc;
		busSel.rf = rfRdEn;
	end

	// Increment takes priority over a bus load
	assign pcNext = incPc ? pcQ + 1'b1 : bus;

	DataReg #(.T(wordT)) uPc (.clock, .arstN, .load(regLoad.pc | incPc), .d(pcNext), .q(pcQ));
	DataReg #(.T(wordT)) uIr (.clock, .arstN, .load(regLoad.ir), .d(bus), .q(irQ));
	DataReg #(.T(wordT)) uRy (.clock, .arstN, .load(regLoad.ry), .d(bus), .q(ryQ));
	DataReg #(.T(dwordT)) uRz (.clock, .arstN, .load(regLoad.rz), .d(aluZ), .q(rzQ));
	DataReg #(.T(wordT)) uHi (.clock, .arstN, .load(regLoad.hi), .d(bus), .q(hiQ));
	DataReg #(.T(wordT)) uLo (.clock, .arstN, .load(regLoad.lo), .d(bus), .q(loQ));

	// I/O ports
	DataReg #(.T(wordT)) uOutport (
		.clock, .arstN, .load(regLoad.outport), .d(bus), .q(deviceOut)
	);
	DataReg #(.T(wordT)) uInport (
		.clock, .arstN, .load(deviceStrobe), .d(deviceIn), .q(inportQ)
	);

	RegSelect uSel (
		.ir(irQ), .gra, .grb, .grc, .rIn, .rOut, .baOut,
		.idx(rfIdx), .wrEn(rfWrEn), .rdEn(rfRdEn), .imm
	);

	RegFile uRf (
		.clock, .arstN, .wrEn(rfWrEn), .idx(rfIdx), .baOut,
		.wrData(bus), .rdData(rfData)
	);

	BranchCond uBranch (.clock, .arstN, .condIn, .ir(irQ), .regVal(rfData), .branch);

	Alu uAlu (
		.clock, .arstN, .start, .op(opSelect), .a(ryQ), .b(bus), .z(aluZ), .finished
	);

	MemSys uMem (
		.clock, .arstN, .read, .write, .marIn(regLoad.mar), .mdrIn(regLoad.mdr),
		.bus, .mdrOut(mdrQ), .memFinished
	);

	BusMux uBus (
		.sel(busSel), .ext(extIn), .rf(rfData), .pc(pcQ), .ir(irQ), .ry(ryQ),
		.rzLo(rzQ[$bits(wordT)-1:0]), .rzHi(rzQ[$bits(dwordT)-1:$bits(wordT)]),
		.hi(hiQ), .lo(loQ), .mdr(mdrQ), .imm, .inport(inportQ), .bus
	);

endmodule

/* tbDataPath.sv */
`timescale 1ns/100ps

module tbDataPath;
	import cpuPkg::*;

	typedef struct packed {
		regIdxT idx;
		wordT val;
	} regCaseT;

	typedef struct packed {
		aluOpT op;
		wordT a;
		wordT b;
	} aluCaseT;

	typedef struct packed {
		wordT addr;
		wordT data;
	} memCaseT;

	// Bit n of mask is the expected flag for condition n
	typedef struct packed {
		wordT val;
		logic [3:0] mask;
	} brCaseT;

	typedef struct packed {
		wordT pcStart;
		wordT steps;
	} pcCaseT;

	localparam int NumRegCases = 4;
	localparam int NumAluFixed = 16;
	localparam int NumAluRand = 8;
	localparam int NumMemCases = 4;
	localparam int NumBrCases = 5;
	localparam int NumPcCases = 3;
	localparam int NumEntries = NumRegCases + 2 + NumAluFixed + NumAluRand + NumMemCases
		+ NumBrCases * 4 + NumPcCases + 1;
	localparam int TimeoutCycles = NumEntries * 50 + 200;

	regCaseT regTable [NumRegCases] = '{
		'{4'd1, 32'h0000_0001}, '{4'd7, 32'hA5A5_5A5A},
		'{4'd12, 32'h8000_0000}, '{4'd15, 32'hFFFF_FFFF}
	};

	aluCaseT aluTable [NumAluFixed] = '{
		'{OP_ADD, 32'h7FFF_FFFF, 32'h0000_0001},
		'{OP_SUB, 32'h0000_0005, 32'h0000_0009},
		'{OP_AND, 32'hF0F0_F0F0, 32'h3C3C_3C3C},
		'{OP_OR, 32'hF0F0_0000, 32'h0000_0F0F},
		'{OP_SHR, 32'h8000_0000, 32'h0000_001F},
		'{OP_SHRA, 32'h8000_0010, 32'h0000_0004},
		'{OP_SHL, 32'h0000_0003, 32'h0000_001E},
		'{OP_ROR, 32'h1234_5678, 32'h0000_0008},
		'{OP_ROL, 32'h1234_5678, 32'h0000_0024},
		'{OP_NEG, 32'h0000_0000, 32'h0000_0005},
		'{OP_NOT, 32'h0000_0000, 32'h0F0F_0000},
		'{OP_MUL, 32'h0000_0007, 32'hFFFF_FFFA},
		'{OP_MUL, 32'h8000_0000, 32'h8000_0000},
		'{OP_DIV, 32'h0000_0064, 32'h0000_0007},
		'{OP_DIV, 32'hFFFF_FF9C, 32'h0000_0007},
		'{OP_DIV, 32'h0012_D687, 32'hFFFF_FFF0}
	};

	memCaseT memTable [NumMemCases] = '{
		'{32'h0000_0000, 32'hCAFE_0001}, '{32'h0000_0001, 32'h1357_9BDF},
		'{32'h0000_00FF, 32'h8000_0001}, '{32'h0000_01FF, 32'hFFFF_0000}
	};

	brCaseT brTable [NumBrCases] = '{
		'{32'h0000_0000, 4'b0001}, '{32'h0000_0005, 4'b0110},
		'{32'hFFFF_FFFD, 4'b1010}, '{32'h8000_0000, 4'b1010},
		'{32'h7FFF_FFFF, 4'b0110}
	};

	pcCaseT pcTable [NumPcCases] = '{
		'{32'h0000_0000, 32'd3}, '{32'h0000_0100, 32'd7}, '{32'hFFFF_FFFE, 32'd4}
	};

	logic clock;
	logic arstN;
	busSrcT busSrc;
	regLoadT regLoad;
	logic gra, grb, grc, rIn, rOut, baOut, incPc, condIn;
	logic start, read, write, deviceStrobe;
	aluOpT opSelect;
	wordT extIn;
	wordT deviceIn;
	logic finished;
	logic memFinished;
	logic branch;
	wordT deviceOut;

	aluCaseT aluRand [NumAluRand];
	wordT lcgState;
	int cycleCount = 0;
	int checkCount = 0;
	int errCount = 0;

	DataPath UUT (
		.clock, .arstN, .busSrc, .regLoad, .gra, .grb, .grc, .rIn, .rOut, .baOut,
		.incPc, .condIn, .start, .read, .write, .deviceStrobe, .opSelect, .extIn,
		.deviceIn, .finished, .memFinished, .branch, .deviceOut
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles) begin
			$display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	function automatic wordT lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Expected ALU result, quotient low and remainder high for DIV
	function automatic dwordT aluModel(input aluOpT op, input wordT a, input wordT b);
		int unsigned n;
		longint sa;
		longint sb;
		wordT r;
		n = b[4:0];
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		r = '0;
		case (op)
			OP_ADD: r = a + b;
			OP_SUB: r = a - b;
			OP_AND: r = a & b;
			OP_OR: r = a | b;
			OP_SHR: r = a >> n;
			OP_SHRA: r = $signed(a) >>> n;
			OP_SHL: r = a << n;
			OP_ROR: r = (a >> n) | (a << (32 - n));
			OP_ROL: r = (a << n) | (a >> (32 - n));
			OP_NEG: r = -b;
			OP_NOT: r = ~b;
			OP_MUL: return sa * sb;
			OP_DIV: return {wordT'(sa % sb), wordT'(sa / sb)};
			default: r = '0;
		endcase
		return {32'h0, r};
	endfunction

	task automatic checkWord(input wordT got, input wordT want, input string what);
		checkCount++;
		if (got !== want) begin
			errCount++;
			$display("CHECK FAILED at time %0t: %s: expected %h, got %h",
				$time, what, want, got);
		end
	endtask

	task automatic clearCtrl();
		busSrc <= '0;
		regLoad <= '0;
		gra <= 1'b0;
		grb <= 1'b0;
		grc <= 1'b0;
		rIn <= 1'b0;
		rOut <= 1'b0;
		baOut <= 1'b0;
		incPc <= 1'b0;
		condIn <= 1'b0;
		start <= 1'b0;
		read <= 1'b0;
		write <= 1'b0;
		deviceStrobe <= 1'b0;
		opSelect <= OP_ADD;
	endtask

	// Each micro-step starts on a rising edge with all strobes cleared
	task automatic nextStep();
		@(posedge clock);
		clearCtrl();
	endtask

	task automatic extOnBus(input wordT v);
		nextStep();
		busSrc.ext <= 1'b1;
		extIn <= v;
	endtask

	task automatic toOutport();
		nextStep();
		regLoad.outport <= 1'b1;
	endtask

	task automatic checkOut(input wordT want, input string what);
		nextStep();
		@(negedge clock);
		checkWord(deviceOut, want, what);
	endtask

	task automatic loadIr(input wordT v);
		extOnBus(v);
		regLoad.ir <= 1'b1;
	endtask

	task automatic waitMem();
		nextStep();
		@(negedge clock);
		while (!memFinished) begin
			@(negedge clock);
		end
	endtask

	task automatic runAlu(input aluCaseT c);
		dwordT want;
		want = aluModel(c.op, c.a, c.b);
		extOnBus(c.a);
		regLoad.ry <= 1'b1;
		extOnBus(c.b);
		opSelect <= c.op;
		start <= 1'b1;
		// RZ follows Z until the finished cycle
		nextStep();
		regLoad.rz <= 1'b1;
		@(negedge clock);
		while (!finished) begin
			@(negedge clock);
		end
		toOutport();
		busSrc.rzLo <= 1'b1;
		checkOut(want[31:0], $sformatf("ALU %s a=%h b=%h low", c.op.name(), c.a, c.b));
		toOutport();
		busSrc.rzHi <= 1'b1;
		checkOut(want[63:32], $sformatf("ALU %s a=%h b=%h high", c.op.name(), c.a, c.b));
	endtask

	initial begin
		wordT opIdx;
		wordT inVal;
		condT condVal;
		logic lastBranch;
		lcgState = 32'd22;
		arstN = 1'b0;
		busSrc = '0;
		regLoad = '0;
		{gra, grb, grc, rIn, rOut, baOut, incPc, condIn} = '0;
		{start, read, write, deviceStrobe} = '0;
		opSelect = OP_ADD;
		extIn = '0;
		deviceIn = '0;
		for (int i = 0; i < NumAluRand; i++) begin
			opIdx = (lcgNext() >> 8) % 13;
			aluRand[i].op = aluOpT'(opIdx[4:0]);
			aluRand[i].a = lcgNext();
			aluRand[i].b = lcgNext();
			if (aluRand[i].op == OP_DIV && aluRand[i].b == '0) begin
				aluRand[i].b = 32'd1;
			end
		end
		repeat (2) @(posedge clock);
		arstN <= 1'b1;
		@(negedge clock);
		checkWord(wordT'(finished), '0, "finished after reset");
		checkWord(wordT'(memFinished), '0, "memFinished after reset");
		checkWord(wordT'(branch), '0, "branch after reset");
		checkWord(deviceOut, '0, "deviceOut after reset");

		// Write every register first, then read them all back
		foreach (regTable[i]) begin
			loadIr(wordT'(regTable[i].idx) << 23);
			extOnBus(regTable[i].val);
			gra <= 1'b1;
			rIn <= 1'b1;
		end
		foreach (regTable[i]) begin
			loadIr(wordT'(regTable[i].idx) << 23);
			toOutport();
			gra <= 1'b1;
			rOut <= 1'b1;
			checkOut(regTable[i].val, $sformatf("read back r%0d", regTable[i].idx));
		end

		loadIr('0);
		extOnBus(32'hDEAD_BEEF);
		gra <= 1'b1;
		rIn <= 1'b1;
		toOutport();
		gra <= 1'b1;
		rOut <= 1'b1;
		checkOut(32'hDEAD_BEEF, "r0 plain read");
		toOutport();
		gra <= 1'b1;
		rOut <= 1'b1;
		baOut <= 1'b1;
		checkOut('0, "r0 under BAout");

		foreach (aluTable[i]) begin
			runAlu(aluTable[i]);
		end
		foreach (aluRand[i]) begin
			runAlu(aluRand[i]);
		end

		foreach (memTable[i]) begin
			extOnBus(memTable[i].addr);
			regLoad.mar <= 1'b1;
			extOnBus(memTable[i].data);
			regLoad.mdr <= 1'b1;
			nextStep();
			write <= 1'b1;
			waitMem();
		end
		foreach (memTable[i]) begin
			extOnBus(memTable[i].addr);
			regLoad.mar <= 1'b1;
			nextStep();
			read <= 1'b1;
			waitMem();
			toOutport();
			busSrc.mdr <= 1'b1;
			checkOut(memTable[i].data, $sformatf("memory read at %h", memTable[i].addr));
		end

		// ra is r2, the condition sits in bits 20:19
		lastBranch = 1'b0;
		foreach (brTable[i]) begin
			for (int c = 0; c < 4; c++) begin
				condVal = condT'(c[1:0]);
				loadIr({5'b0, 4'd2, 2'b0, c[1:0], 19'b0});
				extOnBus(brTable[i].val);
				gra <= 1'b1;
				rIn <= 1'b1;
				nextStep();
				gra <= 1'b1;
				condIn <= 1'b1;
				// Flag still holds the last evaluated condition
				@(negedge clock);
				checkWord(wordT'(branch), wordT'(lastBranch),
					$sformatf("branch hold %s on %h", condVal.name(), brTable[i].val));
				nextStep();
				@(negedge clock);
				checkWord(wordT'(branch), wordT'(brTable[i].mask[c]),
					$sformatf("branch %s on %h", condVal.name(), brTable[i].val));
				lastBranch = brTable[i].mask[c];
			end
		end

		foreach (pcTable[i]) begin
			extOnBus(pcTable[i].pcStart);
			regLoad.pc <= 1'b1;
			repeat (pcTable[i].steps) begin
				nextStep();
				incPc <= 1'b1;
			end
			toOutport();
			busSrc.pc <= 1'b1;
			checkOut(pcTable[i].pcStart + pcTable[i].steps,
				$sformatf("PC from %h plus %0d", pcTable[i].pcStart, pcTable[i].steps));
		end

		inVal = lcgNext();
		nextStep();
		deviceIn <= inVal;
		deviceStrobe <= 1'b1;
		// Port keeps the strobed word while the device input moves on
		nextStep();
		deviceIn <= ~inVal;
		toOutport();
		busSrc.inport <= 1'b1;
		checkOut(inVal, "inport capture");

		$display("Checks run: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* DataPath.f */
+incdir+.
cpuPkg.sv
DataReg.sv
RegFile.sv
RegSelect.sv
BranchCond.sv
Alu.sv
MemSys.sv
BusMux.sv
DataPath.sv
tbDataPath.sv

/* Bender.yml */
package:
  name: data_path

sources:
  - include_dirs:
      - .
    files:
      - cpuPkg.sv
      - DataReg.sv
      - RegFile.sv
      - RegSelect.sv
      - BranchCond.sv
      - Alu.sv
      - MemSys.sv
      - BusMux.sv
      - DataPath.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbDataPath.sv
